// File: fetch_mem_top.f
logic/fetch_pkg.sv
logic/fetch_unit.sv
logic/mem_arbiter.sv
logic/word_mem.sv
logic/fetch_mem_top.sv
bench/tb_clock.sv
bench/fetch_mem_tb.sv

// File: Makefile
# Verilator build and run of the fetch and memory testbench
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= fetch_mem_tb
FILELIST  ?= fetch_mem_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

# Pass only when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -qxF '>>> PASS' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/fetch_mem_tb.sv
`timescale 1ns/10ps
// ----------------------------------------------------------
// Testbench for fetch_mem_top, random traffic from an LCG
// Instruction words checked only after the data port fills memory
// Watchdog limit follows the sum of the per-test cycle budgets
// ----------------------------------------------------------
module fetch_mem_tb;
  import fetch_pkg::*;

  localparam logic [ADDR_BITS-1:0] RST_ADDR   = 32'h0000_0100;
  localparam int                   MEM_WORDS  = 256;
  // Fetch window in words from RST_ADDR, shared-test writes stay above it
  localparam int                   FETCH_WORDS = 64;
  localparam logic [ADDR_BITS-1:0] WRITE_BASE = 32'h0000_0200;
  localparam int                   BUDGET_SUM = 40 + 2500 + 300 + 600 + 800 + 1500;
  localparam int                   WATCHDOG_NS = (BUDGET_SUM + 200) * 8;

  logic         clk;
  logic         rst;
  logic         inst_val;
  fetch_out_t   inst;
  logic         inst_rdy;
  redirect_t    redirect;
  logic         data_req_val;
  client_req_t  data_req;
  logic         data_req_rdy;
  logic         data_resp_val;
  client_resp_t data_resp;
  logic         data_resp_rdy;

  // Reference model
  logic [31:0]          lcg_state;
  logic [DATA_BITS-1:0] model_mem [MEM_WORDS];
  logic                 mem_valid;
  logic [ADDR_BITS-1:0] exp_pc;
  client_req_t          req_q [$];
  client_resp_t         resp_q [$];
  logic                 req_taken;
  logic                 stalled;
  fetch_out_t           held_inst;
  logic                 reset_watch;

  // Traffic knobs, percent per cycle
  int inst_rdy_pct;
  int squash_pct;
  int target_span;
  int req_pct;
  int resp_rdy_pct;

  int err_count;
  int test_count;
  int inst_count;
  int data_count;
  int test_insts;

  tb_clock #(.RST_CYCLES(5)) u_clock (.clk(clk), .rst(rst));

  fetch_mem_top #(
    .RST_ADDR  (RST_ADDR),
    .MEM_WORDS (MEM_WORDS)
  ) UUT (
    .clk           (clk),
    .rst           (rst),
    .inst_val      (inst_val),
    .inst          (inst),
    .inst_rdy      (inst_rdy),
    .redirect      (redirect),
    .data_req_val  (data_req_val),
    .data_req      (data_req),
    .data_req_rdy  (data_req_rdy),
    .data_resp_val (data_resp_val),
    .data_resp     (data_resp),
    .data_resp_rdy (data_resp_rdy)
  );

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // High bits only, the low LCG bits cycle too fast
  function automatic logic chance(int pct);
    return int'((lcg_next() >> 16) % 100) < pct;
  endfunction

  // Memory wraps on the word index
  function automatic int word_index(logic [ADDR_BITS-1:0] addr);
    return int'((addr >> 2) % MEM_WORDS);
  endfunction

  task automatic report_mismatch(string name, logic [63:0] exp, logic [63:0] act);
    $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
    err_count++;
  endtask

  task automatic report_error(string what);
    $display("ERROR time=%0t %s", $time, what);
    err_count++;
  endtask

  task automatic queue_request(mem_op_e op, logic [ADDR_BITS-1:0] addr);
    client_req_t r;
    r.op     = op;
    r.opaque = OPAQUE_BITS'(lcg_next() >> 7);
    r.addr   = addr;
    r.data   = (op == mem_write) ? lcg_next() : '0;
    req_q.push_back(r);
  endtask

  task automatic set_traffic(int rdy, int sq, int span, int req, int resp);
    inst_rdy_pct = rdy;
    squash_pct   = sq;
    target_span  = span;
    req_pct      = req;
    resp_rdy_pct = resp;
  endtask

  // ----------------------------------------------------------
  // Per-cycle sampling and driving
  // ----------------------------------------------------------

  // Mid-cycle values show what transfers at the next rising edge
  task automatic sample_cycle();
    client_resp_t exp_r;
    int           idx;
    // Checked through reset and one cycle past release
    if (reset_watch) begin
      if (inst_val !== 1'b0) report_error("inst_val high during or just after reset");
      if (data_resp_val !== 1'b0) report_error("data_resp_val high during or just after reset");
      reset_watch = rst;
    end
    // Stalled instruction holds unless squashed away
    if (stalled && !redirect.squash) begin
      if (inst_val !== 1'b1) report_error("inst_val dropped while decode stalled");
      else if (inst !== held_inst) report_mismatch("inst (held)", held_inst, inst);
    end
    stalled   = inst_val && !inst_rdy;
    held_inst = inst;
    if (inst_val && inst_rdy) begin
      inst_count++;
      test_insts++;
      idx = word_index(exp_pc);
      if (inst.pc !== exp_pc) report_mismatch("inst.pc", exp_pc, inst.pc);
      if (mem_valid && inst.inst !== model_mem[idx]) begin
        report_mismatch("inst.inst", model_mem[idx], inst.inst);
      end
      exp_pc = exp_pc + 32'd4;
    end
    // Squash cycles never deliver, so the target is next
    if (redirect.squash) exp_pc = redirect.branch_target;
    if (data_resp_val && data_resp_rdy) begin
      data_count++;
      if (resp_q.size() == 0) begin
        report_error("data response with no data request outstanding");
      end else begin
        exp_r = resp_q.pop_front();
        if (data_resp.op !== exp_r.op) report_mismatch("data_resp.op", exp_r.op, data_resp.op);
        if (data_resp.opaque !== exp_r.opaque) begin
          report_mismatch("data_resp.opaque", exp_r.opaque, data_resp.opaque);
        end
        if (data_resp.addr !== exp_r.addr) begin
          report_mismatch("data_resp.addr", exp_r.addr, data_resp.addr);
        end
        if (data_resp.data !== exp_r.data) begin
          report_mismatch("data_resp.data", exp_r.data, data_resp.data);
        end
      end
    end
    // Request model updates last, a same-edge delivery read older state
    req_taken = data_req_val && data_req_rdy;
    if (req_taken) begin
      idx          = word_index(data_req.addr);
      exp_r.op     = data_req.op;
      exp_r.opaque = data_req.opaque;
      exp_r.addr   = data_req.addr;
      if (data_req.op == mem_write) model_mem[idx] = data_req.data;
      exp_r.data   = model_mem[idx];
      resp_q.push_back(exp_r);
    end
  endtask

  task automatic drive_cycle();
    if (req_taken) void'(req_q.pop_front());
    // Pending request holds until it transfers
    if (!data_req_val || req_taken) begin
      if (req_q.size() > 0 && chance(req_pct)) begin
        data_req_val <= 1'b1;
        data_req     <= req_q[0];
      end else begin
        data_req_val <= 1'b0;
      end
    end
    inst_rdy      <= chance(inst_rdy_pct);
    data_resp_rdy <= chance(resp_rdy_pct);
    // Word-aligned target inside the fetch window
    if (chance(squash_pct)) begin
      redirect <= {1'b1, RST_ADDR + ((lcg_next() % target_span) << 2)};
    end else begin
      redirect.squash <= 1'b0;
    end
  endtask

  task automatic run_cycle();
    @(negedge clk);
    sample_cycle();
    @(posedge clk);
    drive_cycle();
  endtask

  // Runs until enough deliveries and the data port drained, or the budget ends
  task automatic run_test(int num, string name, int budget, int min_insts);
    int   cycles;
    int   errs_before;
    logic done;
    cycles      = 0;
    errs_before = err_count;
    test_insts  = 0;
    done        = (min_insts == 0) && req_q.size() == 0 && resp_q.size() == 0;
    while (!done && cycles < budget) begin
      run_cycle();
      cycles++;
      done = test_insts >= min_insts && req_q.size() == 0 && resp_q.size() == 0;
    end
    if (!done) begin
      report_error($sformatf("test %0d did not finish within %0d cycles", num, budget));
    end
    test_count++;
    $display("test %0d %s: %0d cycles, %0d errors", num, name, cycles, err_count - errs_before);
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------

  initial begin
    lcg_state     = 32'h5ca1;
    err_count     = 0;
    test_count    = 0;
    inst_count    = 0;
    data_count    = 0;
    mem_valid     = 1'b0;
    exp_pc        = RST_ADDR;
    stalled       = 1'b0;
    held_inst     = '0;
    req_taken     = 1'b0;
    reset_watch   = 1'b1;
    inst_rdy      <= 1'b1;
    redirect      <= '0;
    data_req_val  <= 1'b0;
    data_req      <= '0;
    data_resp_rdy <= 1'b1;
    @(posedge clk);

    // Reset state first, memory still unknown so only pc is checked
    set_traffic(100, 0, 1, 0, 100);
    run_test(6, "reset state", 40, 4);

    // Squash held every cycle, so fetch responses drain while decode stalls
    set_traffic(0, 100, 1, 90, 90);
    for (int i = 0; i < MEM_WORDS; i++) queue_request(mem_write, 32'(4 * i));
    for (int i = 0; i < MEM_WORDS; i++) queue_request(mem_read, 32'(4 * i));
    run_test(1, "data write then read", 2500, 0);
    mem_valid = 1'b1;

    // Last held squash aimed at RST_ADDR
    set_traffic(100, 0, 1, 0, 100);
    run_test(2, "sequential fetch", 300, 64);

    set_traffic(100, 10, FETCH_WORDS, 0, 100);
    run_test(3, "squash redirect", 600, 100);

    set_traffic(50, 0, 1, 0, 100);
    run_test(4, "decode back-pressure", 800, 100);

    // One forced squash pulls fetch back into its window
    set_traffic(80, 100, 1, 0, 100);
    run_cycle();
    set_traffic(80, 8, FETCH_WORDS, 70, 70);
    for (int i = 0; i < 60; i++) begin
      if (chance(50)) queue_request(mem_write, WRITE_BASE + ((lcg_next() % 128) << 2));
      else queue_request(mem_read, (lcg_next() % MEM_WORDS) << 2);
    end
    run_test(5, "shared access", 1500, 40);

    $display("tests=%0d instructions=%0d data_responses=%0d errors=%0d",
             test_count, inst_count, data_count, err_count);
    if (err_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("ERROR watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/10ps
// ----------------------------------------------------------
// Testbench clock, 8 ns period starting low
// Reset high from time 0, released after RST_CYCLES rising edges
// ----------------------------------------------------------
module tb_clock #(
  parameter int RST_CYCLES = 5
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Release lands on a rising edge like any other input
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// File: logic/fetch_mem_top.sv
`timescale 1ns/10ps
// ----------------------------------------------------------
// Fetch unit and data port sharing one word memory
// Decode stall holds memory and blocks the data port too
// ----------------------------------------------------------
module fetch_mem_top #(
  parameter logic [fetch_pkg::ADDR_BITS-1:0] RST_ADDR  = '0,
  parameter int                              MEM_WORDS = 256
) (
  input  logic                    clk,
  input  logic                    rst,

  // Decode side
  output logic                    inst_val,
  output fetch_pkg::fetch_out_t   inst,
  input  logic                    inst_rdy,
  input  fetch_pkg::redirect_t    redirect,

  // External data port
  input  logic                    data_req_val,
  input  fetch_pkg::client_req_t  data_req,
  output logic                    data_req_rdy,
  output logic                    data_resp_val,
  output fetch_pkg::client_resp_t data_resp,
  input  logic                    data_resp_rdy
);
  import fetch_pkg::*;

  // Fetch to arbiter
  logic         fetch_req_val;
  client_req_t  fetch_req;
  logic         fetch_req_rdy;
  logic         fetch_resp_val;
  client_resp_t fetch_resp;
  logic         fetch_resp_rdy;

  // Arbiter to memory
  logic         mem_req_val;
  mem_req_t     mem_req;
  logic         mem_req_rdy;
  logic         mem_resp_val;
  mem_resp_t    mem_resp;
  logic         mem_resp_rdy;

  fetch_unit #(
    .RST_ADDR (RST_ADDR)
  ) u_fetch (
    .clk      (clk),
    .rst      (rst),
    .req_val  (fetch_req_val),
    .req_msg  (fetch_req),
    .req_rdy  (fetch_req_rdy),
    .resp_val (fetch_resp_val),
    .resp_msg (fetch_resp),
    .resp_rdy (fetch_resp_rdy),
    .inst_val (inst_val),
    .inst     (inst),
    .inst_rdy (inst_rdy),
    .redirect (redirect)
  );

  mem_arbiter u_arb (
    .clk            (clk),
    .rst            (rst),
    .fetch_req_val  (fetch_req_val),
    .fetch_req      (fetch_req),
    .fetch_req_rdy  (fetch_req_rdy),
    .fetch_resp_val (fetch_resp_val),
    .fetch_resp     (fetch_resp),
    .fetch_resp_rdy (fetch_resp_rdy),
    .data_req_val   (data_req_val),
    .data_req       (data_req),
    .data_req_rdy   (data_req_rdy),
    .data_resp_val  (data_resp_val),
    .data_resp      (data_resp),
    .data_resp_rdy  (data_resp_rdy),
    .mem_req_val    (mem_req_val),
    .mem_req        (mem_req),
    .mem_req_rdy    (mem_req_rdy),
    .mem_resp_val   (mem_resp_val),
    .mem_resp       (mem_resp),
    .mem_resp_rdy   (mem_resp_rdy)
  );

  word_mem #(
    .MEM_WORDS (MEM_WORDS)
  ) u_mem (
    .clk      (clk),
    .rst      (rst),
    .req_val  (mem_req_val),
    .req      (mem_req),
    .req_rdy  (mem_req_rdy),
    .resp_val (mem_resp_val),
    .resp     (mem_resp),
    .resp_rdy (mem_resp_rdy)
  );

endmodule

// File: logic/word_mem.sv
`timescale 1ns/10ps
// ----------------------------------------------------------
// Single-port word memory answering one cycle after acceptance
// Index is addr[31:2] modulo MEM_WORDS
// Contents not reset
// One output slot held unchanged under back-pressure
// ----------------------------------------------------------
module word_mem #(
  parameter int MEM_WORDS = 256
) (
  input  logic                 clk,
  input  logic                 rst,

  // Request from arbiter
  input  logic                 req_val,
  input  fetch_pkg::mem_req_t  req,
  output logic                 req_rdy,

  // Response to arbiter
  output logic                 resp_val,
  output fetch_pkg::mem_resp_t resp,
  input  logic                 resp_rdy
);
  import fetch_pkg::*;

  localparam int IDX_BITS = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  logic [DATA_BITS-1:0] mem_array [MEM_WORDS];
  logic [IDX_BITS-1:0]  word_idx;
  logic                 req_xfer;
  logic [DATA_BITS-1:0] resp_data;

  // Slot free, or emptied this cycle
  assign req_rdy  = !resp_val || resp_rdy;
  assign req_xfer = req_val && req_rdy;

  // Word index with wrap at the memory depth
  assign word_idx = IDX_BITS'(req.msg.addr[ADDR_BITS-1:2] % MEM_WORDS);

  // Write returns its own data
  assign resp_data = (req.msg.op == mem_write) ? req.msg.data : mem_array[word_idx];

  // ----------------------------------------------------------
  // Storage
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (req_xfer && req.msg.op == mem_write) begin
      mem_array[word_idx] <= req.msg.data;
    end
  end

  // ----------------------------------------------------------
  // Output slot
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      resp_val <= 1'b0;
    end else if (req_xfer) begin
      resp_val <= 1'b1;
    end else if (resp_rdy) begin
      resp_val <= 1'b0;
    end
  end

  // Payload loads only on acceptance
  always_ff @(posedge clk) begin
    if (req_xfer) begin
      resp.src        <= req.src;
      resp.msg.op     <= req.msg.op;
      resp.msg.opaque <= req.msg.opaque;
      resp.msg.addr   <= req.msg.addr;
      resp.msg.data   <= resp_data;
    end
  end

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------

  // Stalled response stays put until taken
  a_resp_hold : assert property (
    @(posedge clk) disable iff (rst)
    (resp_val && !resp_rdy) |=> resp_val && $stable(resp)
  ) else $error("word_mem: response changed while stalled");

endmodule

// File: logic/mem_arbiter.sv
`timescale 1ns/10ps
// ----------------------------------------------------------
// Round-robin arbiter for fetch and data clients onto one memory
// Pointer moves only on a memory request transfer
// Responses routed back by the echoed src tag
// ----------------------------------------------------------
module mem_arbiter (
  input  logic                    clk,
  input  logic                    rst,

  // Fetch client
  input  logic                    fetch_req_val,
  input  fetch_pkg::client_req_t  fetch_req,
  output logic                    fetch_req_rdy,
  output logic                    fetch_resp_val,
  output fetch_pkg::client_resp_t fetch_resp,
  input  logic                    fetch_resp_rdy,

  // Data client
  input  logic                    data_req_val,
  input  fetch_pkg::client_req_t  data_req,
  output logic                    data_req_rdy,
  output logic                    data_resp_val,
  output fetch_pkg::client_resp_t data_resp,
  input  logic                    data_resp_rdy,

  // Memory side
  output logic                    mem_req_val,
  output fetch_pkg::mem_req_t     mem_req,
  input  logic                    mem_req_rdy,
  input  logic                    mem_resp_val,
  input  fetch_pkg::mem_resp_t    mem_resp,
  output logic                    mem_resp_rdy
);
  import fetch_pkg::*;

  mem_src_e last_src;
  logic     grant_fetch;
  logic     grant_data;

  // ----------------------------------------------------------
  // Request side
  // ----------------------------------------------------------

  // Data wins a tie only when fetch went last
  assign grant_data  = data_req_val && (!fetch_req_val || last_src == src_fetch);
  assign grant_fetch = fetch_req_val && !grant_data;

  assign mem_req_val = fetch_req_val || data_req_val;
  assign mem_req.src = grant_data ? src_data : src_fetch;
  assign mem_req.msg = grant_data ? data_req : fetch_req;

  // Only the granted client sees rdy
  assign fetch_req_rdy = grant_fetch && mem_req_rdy;
  assign data_req_rdy  = grant_data && mem_req_rdy;

  // Reset value lets fetch go first
  always_ff @(posedge clk) begin
    if (rst) begin
      last_src <= src_data;
    end else if (mem_req_val && mem_req_rdy) begin
      last_src <= mem_req.src;
    end
  end

  // ----------------------------------------------------------
  // Response side
  // ----------------------------------------------------------

  assign fetch_resp_val = mem_resp_val && (mem_resp.src == src_fetch);
  assign data_resp_val  = mem_resp_val && (mem_resp.src == src_data);
  assign fetch_resp     = mem_resp.msg;
  assign data_resp      = mem_resp.msg;

  // Back-pressure from the addressed client only
  assign mem_resp_rdy = (mem_resp.src == src_data) ? data_resp_rdy : fetch_resp_rdy;

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------

  a_one_grant : assert property (
    @(posedge clk) disable iff (rst) !(fetch_req_rdy && data_req_rdy)
  ) else $error("mem_arbiter: both clients granted");

endmodule

// File: logic/fetch_unit.sv
`timescale 1ns/10ps
// ----------------------------------------------------------
// Sequential read fetch with up to 2**OPAQUE_BITS requests in flight
// Squash redirects in the same cycle and bumps the epoch tag
// Epoch wraps, so a stale response must drain within that many squashes
// ----------------------------------------------------------
module fetch_unit #(
  parameter logic [fetch_pkg::ADDR_BITS-1:0] RST_ADDR = '0
) (
  input  logic                    clk,
  input  logic                    rst,

  // Memory request
  output logic                    req_val,
  output fetch_pkg::client_req_t  req_msg,
  input  logic                    req_rdy,

  // Memory response
  input  logic                    resp_val,
  input  fetch_pkg::client_resp_t resp_msg,
  output logic                    resp_rdy,

  // Decode side
  output logic                    inst_val,
  output fetch_pkg::fetch_out_t   inst,
  input  logic                    inst_rdy,
  input  fetch_pkg::redirect_t    redirect
);
  import fetch_pkg::*;

  localparam int MAX_IN_FLIGHT = 2 ** OPAQUE_BITS;

  logic                   req_xfer;
  logic                   resp_xfer;
  logic [OPAQUE_BITS:0]   in_flight;
  logic [ADDR_BITS-1:0]   curr_addr;
  logic [ADDR_BITS-1:0]   issue_addr;
  logic [OPAQUE_BITS-1:0] epoch;
  logic [OPAQUE_BITS-1:0] epoch_next;
  logic                   drop;

  assign req_xfer  = req_val && req_rdy;
  assign resp_xfer = resp_val && resp_rdy;

  // ----------------------------------------------------------
  // In-flight count
  // ----------------------------------------------------------

  // Request and response in the same cycle cancel out
  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= '0;
    end else if (req_xfer && !resp_xfer) begin
      in_flight <= in_flight + 1'b1;
    end else if (resp_xfer && !req_xfer) begin
      in_flight <= in_flight - 1'b1;
    end
  end

  // Stop issuing at the limit
  assign req_val = (in_flight < MAX_IN_FLIGHT);

  // ----------------------------------------------------------
  // Request address and epoch
  // ----------------------------------------------------------

  // Squash overrides the held address in its own cycle
  assign issue_addr = redirect.squash ? redirect.branch_target : curr_addr;
  assign epoch_next = epoch + 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      curr_addr <= RST_ADDR;
    end else if (req_xfer) begin
      // Covers a squash that transfers in the same cycle
      curr_addr <= issue_addr + 32'd4;
    end else if (redirect.squash) begin
      curr_addr <= redirect.branch_target;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      epoch <= '0;
    end else if (redirect.squash) begin
      epoch <= epoch_next;
    end
  end

  always_comb begin
    req_msg.op     = mem_read;
    // New epoch already on the redirected request
    req_msg.opaque = redirect.squash ? epoch_next : epoch;
    req_msg.addr   = issue_addr;
    // Reads carry no payload
    req_msg.data   = '0;
  end

  // ----------------------------------------------------------
  // Response filtering
  // ----------------------------------------------------------

  // Old epoch or anything landing during a squash is wrong-path
  assign drop = (resp_msg.opaque != epoch) || redirect.squash;

  // Dropped responses drain even when decode stalls
  assign resp_rdy  = inst_rdy || drop;
  assign inst_val  = resp_val && !drop;
  assign inst.pc   = resp_msg.addr;
  assign inst.inst = resp_msg.data;

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------

  // Limit holds across arbiter and memory latency
  a_in_flight_limit : assert property (
    @(posedge clk) disable iff (rst) in_flight <= MAX_IN_FLIGHT
  ) else $error("fetch_unit: in-flight count above limit");

  // Memory never answers a request fetch did not send
  a_no_orphan_resp : assert property (
    @(posedge clk) disable iff (rst) resp_xfer |-> (in_flight != '0)
  ) else $error("fetch_unit: response with nothing in flight");

  // Fetch responses are always reads
  a_resp_is_read : assert property (
    @(posedge clk) disable iff (rst) resp_val |-> resp_msg.op == mem_read
  ) else $error("fetch_unit: write response routed to fetch");

endmodule

// File: logic/fetch_pkg.sv
// ----------------------------------------------------------
// Shared widths, enums and link structs for fetch and memory
// Word addressed memory, byte addresses with bits [1:0] ignored
// No sub-word access and no error response
// ----------------------------------------------------------
package fetch_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------

  // Byte address
  parameter int ADDR_BITS   = 32;
  // Instruction and data word
  parameter int DATA_BITS   = 32;
  // Epoch tag carried through memory
  parameter int OPAQUE_BITS = 2;

  // ----------------------------------------------------------
  // Enums
  // ----------------------------------------------------------

  typedef enum logic {
    mem_read  = 1'b0,
    mem_write = 1'b1
  } mem_op_e;

  // Which client issued a memory request
  typedef enum logic {
    src_fetch = 1'b0,
    src_data  = 1'b1
  } mem_src_e;

  // ----------------------------------------------------------
  // Link structs
  // ----------------------------------------------------------

  // Client to arbiter, 67 bits
  typedef struct packed {
    mem_op_e                op;
    logic [OPAQUE_BITS-1:0] opaque;
    logic [ADDR_BITS-1:0]   addr;
    logic [DATA_BITS-1:0]   data;
  } client_req_t;

  // Arbiter to client, addr echoes the request
  typedef struct packed {
    mem_op_e                op;
    logic [OPAQUE_BITS-1:0] opaque;
    logic [ADDR_BITS-1:0]   addr;
    logic [DATA_BITS-1:0]   data;
  } client_resp_t;

  // Arbiter to memory with source tag, 68 bits
  typedef struct packed {
    mem_src_e    src;
    client_req_t msg;
  } mem_req_t;

  // Memory to arbiter, src echoed for routing
  typedef struct packed {
    mem_src_e     src;
    client_resp_t msg;
  } mem_resp_t;

  // Fetch to decode
  typedef struct packed {
    logic [ADDR_BITS-1:0] pc;
    logic [DATA_BITS-1:0] inst;
  } fetch_out_t;

  // Decode to fetch, squash is a one-cycle strobe
  typedef struct packed {
    logic                 squash;
    logic [ADDR_BITS-1:0] branch_target;
  } redirect_t;

endpackage
